// ==== sim.f ====
source/qdec_pkg.sv
source/qdec_bundle_latch.sv
source/qdec_const_decode.sv
source/qdec_operand_select.sv
source/qdec_top.sv
sim/qdec_sva.sv
sim/qdec_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the constant-decode testbench with Verilator, runs it and checks the log
set -e -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module qdec_tb -f sim.f -o qdec_sim

status=0
./obj_dir/qdec_sim 2>&1 | tee sim.log || status=$?

if [ "$status" -ne 0 ] || grep -q "test failed" sim.log; then
	echo "simulation reported a failure, see sim.log"
	exit 1
fi
echo "simulation finished cleanly"

// ==== sim/qdec_tb.sv ====
// Testbench for the constant-decode stage that runs a stimulus table and random bundles
`timescale 1ns/1ps
`default_nettype none

module qdec_tb;

	localparam int NUM_PARCELS = 4;
	localparam int BUNDLE_W = NUM_PARCELS * qdec_pkg::PARCEL_W;
	localparam int CLK_PERIOD = 100;
	localparam int TABLE_LEN = 19;
	localparam int RAND_COUNT = 24;
	localparam int WATCHDOG_CYCLES = (TABLE_LEN + RAND_COUNT + 10) * 4;
	localparam logic [qdec_pkg::PARCEL_W-1:0] NO_PFX = '0;

	// One bundle of the stimulus table, the mask column holds the expected flags
	typedef struct packed {
		logic [7:0]                         opcode;
		logic [qdec_pkg::REG_W-1:0]         rd;
		logic [qdec_pkg::REG_W-1:0]         rs1;
		logic [qdec_pkg::IMM_W-1:0]         imm;
		qdec_pkg::pc_address_t              ip;
		logic [2:0][qdec_pkg::PARCEL_W-1:0] pfx;
		logic [1:0]                         gap;
		logic [3:0]                         mask;
	} row_t;

	// Expected result of one bundle, its read indices and the cycle it is due in
	typedef struct packed {
		logic [qdec_pkg::VALUE_W-1:0] a;
		logic [qdec_pkg::VALUE_W-1:0] b;
		logic [qdec_pkg::VALUE_W-1:0] c;
		logic [qdec_pkg::VALUE_W-1:0] d;
		logic [3:0]                   mask;
		logic [qdec_pkg::REG_W-1:0]   rd;
		logic [qdec_pkg::REG_W-1:0]   rs1;
		logic [qdec_pkg::REG_W-1:0]   rs2;
		int                           due;
	} exp_t;

	logic                         clk = 1'b0;
	logic                         rst_n;
	logic                         in_valid;
	logic [BUNDLE_W-1:0]          instr_raw;
	qdec_pkg::pc_address_t        ip;
	logic [qdec_pkg::VALUE_W-1:0] rf_a;
	logic [qdec_pkg::VALUE_W-1:0] rf_b;
	logic [qdec_pkg::REG_W-1:0]   rs1_idx;
	logic [qdec_pkg::REG_W-1:0]   rs2_idx;
	logic                         out_valid;
	logic [qdec_pkg::VALUE_W-1:0] opnd_a;
	logic [qdec_pkg::VALUE_W-1:0] opnd_b;
	logic [qdec_pkg::VALUE_W-1:0] opnd_c;
	logic [qdec_pkg::VALUE_W-1:0] opnd_d;
	logic [3:0]                   imm_mask;
	logic [qdec_pkg::REG_W-1:0]   out_rd;

	row_t        stim_rows [TABLE_LEN];
	exp_t        exp_q [$];
	int          cyc = 0;
	int          value_errors = 0;
	int          protocol_errors = 0;
	logic        check_after_reset = 1'b0;
	logic [31:0] rng;

	qdec_top #(
		.NUM_PARCELS(NUM_PARCELS)
	) qdec_top_i (
		.clk(clk), .rst_n(rst_n), .in_valid(in_valid), .instr_raw(instr_raw), .ip(ip),
		.rf_a(rf_a), .rf_b(rf_b), .rs1_idx(rs1_idx), .rs2_idx(rs2_idx),
		.out_valid(out_valid), .opnd_a(opnd_a), .opnd_b(opnd_b), .opnd_c(opnd_c),
		.opnd_d(opnd_d), .imm_mask(imm_mask), .out_rd(out_rd)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Cycle count used to place every result on its due edge
	always @(posedge clk) cyc <= cyc + 1;

	// ======================================================================
	// Register file model and reference model
	// ======================================================================

	function automatic logic [qdec_pkg::VALUE_W-1:0] rf_read(input logic [qdec_pkg::REG_W-1:0] idx);
		if (idx == '0) begin
			return '0;
		end
		return 64'h5a00_0000_0000_0000 + {58'd0, idx};
	endfunction

	// The register file answers combinationally for the latched indices
	assign rf_a = rf_read(rs1_idx);
	assign rf_b = rf_read(rs2_idx);

	function automatic exp_t compute_expected(input row_t r);
		logic [qdec_pkg::VALUE_W-1:0]  v [4];
		logic [3:0]                    h;
		logic [18:0]                   disp;
		logic [qdec_pkg::PARCEL_W-1:0] p;
		exp_t                          e;
		disp = r.imm[26:8];
		for (int i = 0; i < 4; i++) begin
			v[i] = '0;
		end
		h = 4'b0000;
		case (r.opcode)
			qdec_pkg::op_addi, qdec_pkg::op_subfi, qdec_pkg::op_cmpi: begin
				v[1] = {{37{r.imm[26]}}, r.imm};
				h[1] = 1'b1;
			end
			qdec_pkg::op_cmpui, qdec_pkg::op_ori, qdec_pkg::op_xori: begin
				v[1] = {37'd0, r.imm};
				h[1] = 1'b1;
			end
			qdec_pkg::op_andi: begin
				v[1] = {{37{1'b1}}, r.imm};
				h[1] = 1'b1;
			end
			qdec_pkg::op_loadi: begin
				v[1] = {{37{r.imm[26]}}, r.imm};
				h = 4'b0011;
			end
			// Zero registers turn into present zero constants
			qdec_pkg::op_load, qdec_pkg::op_store, qdec_pkg::op_ldip: begin
				h[0] = (r.rs1 == '0);
				h[1] = (r.imm[5:0] == 6'd0);
				v[2] = {{45{disp[18]}}, disp};
				h[2] = 1'b1;
				if (r.opcode == qdec_pkg::op_ldip) begin
					v[0] = r.ip;
					h[0] = 1'b1;
				end
			end
			default: begin
				h = 4'b0000;
			end
		endcase
		// Prefix parcels in order, quarters 2 and 3 change nothing
		for (int i = 0; i < 3; i++) begin
			p = r.pfx[i];
			if (p[7:0] == qdec_pkg::op_cpfx && p[11:10] == 2'd0) begin
				v[p[9:8]] = {{32{p[47]}}, p[47:16]};
				h[p[9:8]] = 1'b1;
			end else if (p[7:0] == qdec_pkg::op_cpfx && p[11:10] == 2'd1) begin
				v[p[9:8]][63:32] = p[47:16];
				h[p[9:8]] = 1'b1;
			end
		end
		e.a = h[0] ? v[0] : rf_read(r.rs1);
		e.b = h[1] ? v[1] : rf_read(r.imm[5:0]);
		e.c = v[2];
		e.d = v[3];
		e.mask = h;
		e.rd = r.rd;
		e.rs1 = r.rs1;
		e.rs2 = r.imm[5:0];
		e.due = 0;
		return e;
	endfunction

	// ======================================================================
	// Stimulus helpers
	// ======================================================================

	function automatic logic [qdec_pkg::PARCEL_W-1:0] make_prefix(input logic [1:0] wh,
			input logic [1:0] q, input logic [31:0] val);
		return {val, 4'h0, q, wh, 8'd127};
	endfunction

	// Memory form immediate with the displacement on top and rs2 at the bottom
	function automatic logic [qdec_pkg::IMM_W-1:0] mem_imm(input logic [18:0] disp,
			input logic [5:0] rs2);
		return {disp, 2'b00, rs2};
	endfunction

	function automatic row_t make_row(input logic [7:0] opcode, input logic [5:0] rd,
			input logic [5:0] rs1, input logic [26:0] imm, input logic [63:0] ip_val,
			input logic [47:0] p1, input logic [47:0] p2, input logic [47:0] p3,
			input logic [1:0] gap, input logic [3:0] mask);
		row_t r;
		r.opcode = opcode;
		r.rd = rd;
		r.rs1 = rs1;
		r.imm = imm;
		r.ip = ip_val;
		r.pfx = {p3, p2, p1};
		r.gap = gap;
		r.mask = mask;
		return r;
	endfunction

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic draw(output logic [31:0] v);
		rng = lcg_next(rng);
		v = rng;
	endtask

	function automatic logic [7:0] pick_opcode(input logic [3:0] sel);
		case (sel)
			4'd0: return qdec_pkg::op_addi;
			4'd1: return qdec_pkg::op_subfi;
			4'd2: return qdec_pkg::op_cmpi;
			4'd3: return qdec_pkg::op_cmpui;
			4'd4: return qdec_pkg::op_ori;
			4'd5: return qdec_pkg::op_xori;
			4'd6: return qdec_pkg::op_andi;
			4'd7: return qdec_pkg::op_loadi;
			4'd8: return qdec_pkg::op_load;
			4'd9: return qdec_pkg::op_store;
			4'd10: return qdec_pkg::op_ldip;
			4'd11: return qdec_pkg::op_cpfx;
			default: return 8'h33;
		endcase
	endfunction

	task automatic make_random_row(output row_t r);
		logic [31:0] x;
		logic [31:0] y;
		draw(x);
		draw(y);
		r.opcode = pick_opcode(x[31:28]);
		r.rd = x[27:22];
		r.rs1 = x[21] ? 6'd0 : x[20:15];
		r.gap = (x[14:13] == 2'd3) ? 2'd0 : x[14:13];
		r.mask = 4'b0000;
		r.imm = y[26:0];
		if (x[12]) begin
			r.imm[5:0] = 6'd0;
		end
		draw(x);
		draw(y);
		r.ip = {x, y};
		for (int k = 0; k < 3; k++) begin
			draw(x);
			draw(y);
			// Either a real prefix or a parcel whose opcode byte is not a prefix
			if (x[16]) begin
				r.pfx[k] = make_prefix(x[21:20], x[23:22], y);
			end else begin
				r.pfx[k] = {y, x[31:24], 8'h00};
			end
		end
	endtask

	task automatic build_table();
		stim_rows[0] = make_row(qdec_pkg::op_addi, 6'd1, 6'd3, 27'h7fffff0, 64'h0,
			NO_PFX, NO_PFX, NO_PFX, 2'd0, 4'b0010);
		stim_rows[1] = make_row(qdec_pkg::op_subfi, 6'd2, 6'd5, 27'h0001234, 64'h0,
			NO_PFX, NO_PFX, NO_PFX, 2'd0, 4'b0010);
		stim_rows[2] = make_row(qdec_pkg::op_cmpi, 6'd3, 6'd6, 27'h4000000, 64'h0,
			NO_PFX, NO_PFX, NO_PFX, 2'd1, 4'b0010);
		stim_rows[3] = make_row(qdec_pkg::op_cmpui, 6'd4, 6'd7, 27'h4000001, 64'h0,
			NO_PFX, NO_PFX, NO_PFX, 2'd0, 4'b0010);
		stim_rows[4] = make_row(qdec_pkg::op_ori, 6'd5, 6'd0, 27'h5555555, 64'h0,
			NO_PFX, NO_PFX, NO_PFX, 2'd0, 4'b0010);
		stim_rows[5] = make_row(qdec_pkg::op_xori, 6'd6, 6'd8, 27'h2aaaaaa, 64'h0,
			NO_PFX, NO_PFX, NO_PFX, 2'd2, 4'b0010);
		stim_rows[6] = make_row(qdec_pkg::op_andi, 6'd7, 6'd9, 27'h4abcdef, 64'h0,
			NO_PFX, NO_PFX, NO_PFX, 2'd0, 4'b0010);
		stim_rows[7] = make_row(qdec_pkg::op_loadi, 6'd8, 6'd10, 27'h7000000, 64'h0,
			NO_PFX, NO_PFX, NO_PFX, 2'd1, 4'b0011);
		// Memory forms with zero and non-zero registers
		stim_rows[8] = make_row(qdec_pkg::op_load, 6'd9, 6'd0, mem_imm(19'h40010, 6'd12), 64'h0,
			NO_PFX, NO_PFX, NO_PFX, 2'd0, 4'b0101);
		stim_rows[9] = make_row(qdec_pkg::op_store, 6'd10, 6'd4, mem_imm(19'h00123, 6'd0), 64'h0,
			NO_PFX, NO_PFX, NO_PFX, 2'd1, 4'b0110);
		stim_rows[10] = make_row(qdec_pkg::op_ldip, 6'd11, 6'd2, mem_imm(19'h7ffff, 6'd0),
			64'h0000_1234_5678_9abc, NO_PFX, NO_PFX, NO_PFX, 2'd0, 4'b0111);
		stim_rows[11] = make_row(qdec_pkg::op_ldip, 6'd12, 6'd0, mem_imm(19'h00040, 6'd5),
			64'hffff_0000_0000_1000, NO_PFX, NO_PFX, NO_PFX, 2'd0, 4'b0101);
		// Prefix replace and high half, later prefix wins, quarters 2 and 3 ignored
		stim_rows[12] = make_row(qdec_pkg::op_addi, 6'd13, 6'd11, 27'h0000010, 64'h0,
			make_prefix(2'd0, 2'd0, 32'h8000_0001), make_prefix(2'd1, 2'd1, 32'hdead_beef),
			NO_PFX, 2'd1, 4'b0011);
		stim_rows[13] = make_row(8'h20, 6'd14, 6'd12, 27'h000000d, 64'h0,
			make_prefix(2'd2, 2'd0, 32'h0000_7fff), make_prefix(2'd3, 2'd1, 32'hcafe_f00d),
			make_prefix(2'd2, 2'd0, 32'hffff_0000), 2'd0, 4'b1100);
		stim_rows[14] = make_row(qdec_pkg::op_ori, 6'd15, 6'd13, 27'h0000003, 64'h0,
			make_prefix(2'd3, 2'd2, 32'h1111_1111), make_prefix(2'd0, 2'd3, 32'h2222_2222),
			48'h1234_5678_9a00, 2'd2, 4'b0010);
		stim_rows[15] = make_row(8'hff, 6'd16, 6'd17, 27'h0000021, 64'h0,
			NO_PFX, NO_PFX, NO_PFX, 2'd0, 4'b0000);
		stim_rows[16] = make_row(qdec_pkg::op_loadi, 6'd17, 6'd14, 27'h0000100, 64'h0,
			make_prefix(2'd0, 2'd1, 32'h0000_0001), NO_PFX, NO_PFX, 2'd0, 4'b0011);
		stim_rows[17] = make_row(qdec_pkg::op_load, 6'd18, 6'd0, mem_imm(19'h00008, 6'd0), 64'h0,
			make_prefix(2'd1, 2'd0, 32'h7654_3210), make_prefix(2'd1, 2'd1, 32'h0bad_f00d),
			make_prefix(2'd2, 2'd1, 32'h0000_0001), 2'd1, 4'b0111);
		stim_rows[18] = make_row(qdec_pkg::op_store, 6'd19, 6'd20, mem_imm(19'h00001, 6'd21),
			64'h0, make_prefix(2'd3, 2'd0, 32'hffff_fffe), NO_PFX, NO_PFX, 2'd0, 4'b1100);
	endtask

	// Drives one bundle for a cycle, queues its result and idles for the gap
	task automatic apply_entry(input row_t r, input logic use_table_mask);
		exp_t e;
		@(posedge clk);
		#5;
		in_valid = 1'b1;
		instr_raw = {r.pfx[2], r.pfx[1], r.pfx[0], 1'b0, r.imm, r.rs1, r.rd, r.opcode};
		ip = r.ip;
		e = compute_expected(r);
		if (use_table_mask) begin
			e.mask = r.mask;
		end
		e.due = cyc + 2;
		exp_q.push_back(e);
		repeat (r.gap) begin
			@(posedge clk);
			#5;
			in_valid = 1'b0;
		end
	endtask

	// ======================================================================
	// Compare tasks
	// ======================================================================

	task automatic check_value(input string name, input logic [qdec_pkg::VALUE_W-1:0] got,
			input logic [qdec_pkg::VALUE_W-1:0] exp);
		if (got !== exp) begin
			value_errors++;
			$display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_mask(input string name, input logic [3:0] got, input logic [3:0] exp);
		if (got !== exp) begin
			value_errors++;
			$display("ERR t=%0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_reg(input string name, input logic [qdec_pkg::REG_W-1:0] got,
			input logic [qdec_pkg::REG_W-1:0] exp);
		if (got !== exp) begin
			value_errors++;
			$display("ERR t=%0t %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	// ======================================================================
	// Result monitor, sampled on the falling edge where outputs are stable
	// ======================================================================

	always @(negedge clk) begin : monitor
		exp_t e;
		if (!rst_n) begin
			check_after_reset = 1'b1;
		end else if (check_after_reset) begin
			check_after_reset = 1'b0;
			if (out_valid !== 1'b0) begin
				protocol_errors++;
				$display("out_valid is not low after reset at %0t", $time);
			end
			check_value("opnd_a", opnd_a, '0);
			check_value("opnd_b", opnd_b, '0);
			check_value("opnd_c", opnd_c, '0);
			check_value("opnd_d", opnd_d, '0);
			check_mask("imm_mask", imm_mask, 4'b0000);
			check_reg("out_rd", out_rd, '0);
		end else if (out_valid) begin
			if (exp_q.size() == 0) begin
				protocol_errors++;
				$display("out_valid high at %0t with no bundle outstanding", $time);
			end else begin
				e = exp_q.pop_front();
				if (e.due != cyc) begin
					protocol_errors++;
					$display("result came in cycle %0d but was due in cycle %0d", cyc, e.due);
				end
				check_value("opnd_a", opnd_a, e.a);
				check_value("opnd_b", opnd_b, e.b);
				check_value("opnd_c", opnd_c, e.c);
				check_value("opnd_d", opnd_d, e.d);
				check_mask("imm_mask", imm_mask, e.mask);
				check_reg("out_rd", out_rd, e.rd);
			end
		end else if (exp_q.size() != 0 && exp_q[0].due <= cyc) begin
			// A result whose cycle has passed without out_valid is dropped
			protocol_errors++;
			$display("out_valid missing in cycle %0d for a queued bundle", cyc);
			e = exp_q.pop_front();
		end
		// The read indices belong to the bundle that reaches the outputs next cycle
		foreach (exp_q[i]) begin
			if (exp_q[i].due == cyc + 1) begin
				check_reg("rs1_idx", rs1_idx, exp_q[i].rs1);
				check_reg("rs2_idx", rs2_idx, exp_q[i].rs2);
			end
		end
	end

	initial begin : watchdog
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired with %0d results still outstanding", exp_q.size());
		$display("test failed");
		$finish;
	end

	initial begin : main
		row_t r;
		rst_n = 1'b0;
		in_valid = 1'b0;
		instr_raw = '0;
		ip = '0;
		rng = 32'hc4ad;
		build_table();
		repeat (2) @(posedge clk);
		#5;
		rst_n = 1'b1;
		for (int i = 0; i < TABLE_LEN; i++) begin
			apply_entry(stim_rows[i], 1'b1);
		end
		for (int i = 0; i < RAND_COUNT; i++) begin
			make_random_row(r);
			apply_entry(r, 1'b0);
		end
		@(posedge clk);
		#5;
		in_valid = 1'b0;
		// Drain, then a few idle cycles to catch a stray out_valid
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
		repeat (3) @(posedge clk);
		$display("value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
		if (value_errors + protocol_errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/qdec_sva.sv ====
// Bound assertions on the constant-decode stage for latency, reset state and operand c
`timescale 1ns/1ps
`default_nettype none

module qdec_sva (
	input logic                         clk,
	input logic                         rst_n,
	input logic                         in_valid,
	input logic                         out_valid,
	input logic [qdec_pkg::VALUE_W-1:0] opnd_c,
	input logic [3:0]                   imm_mask
);

	// A bundle leaves the stage exactly two edges after it entered
	latency_two: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid == $past(in_valid, 2))
		else $error("out_valid does not follow in_valid by two cycles");

	// The cycle after a reset edge shows an idle, cleared result register
	reset_clears: assert property (@(posedge clk)
		!rst_n |=> (!out_valid && imm_mask == 4'b0000 && opnd_c == '0))
		else $error("result register not cleared after reset");

	// Operand c has no register path, so an absent constant reads as zero
	c_zero_when_absent: assert property (@(posedge clk) disable iff (!rst_n)
		!imm_mask[2] |-> opnd_c == '0)
		else $error("opnd_c is non-zero while its flag is clear");

endmodule

bind qdec_top qdec_sva qdec_sva_i (
	.clk(clk),
	.rst_n(rst_n),
	.in_valid(in_valid),
	.out_valid(out_valid),
	.opnd_c(opnd_c),
	.imm_mask(imm_mask)
);

`default_nettype wire

// ==== source/qdec_top.sv ====
// Constant-decode stage top level joining the bundle latch, constant decoder and operand selector
`timescale 1ns/1ps
`default_nettype none

module qdec_top #(
	parameter int NUM_PARCELS = 4,
	localparam int BUNDLE_W = NUM_PARCELS * qdec_pkg::PARCEL_W
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          in_valid,
	input  logic [BUNDLE_W-1:0]           instr_raw,
	input  qdec_pkg::pc_address_t         ip,
	input  logic [qdec_pkg::VALUE_W-1:0]  rf_a,
	input  logic [qdec_pkg::VALUE_W-1:0]  rf_b,
	output logic [qdec_pkg::REG_W-1:0]    rs1_idx,
	output logic [qdec_pkg::REG_W-1:0]    rs2_idx,
	output logic                          out_valid,
	output logic [qdec_pkg::VALUE_W-1:0]  opnd_a,
	output logic [qdec_pkg::VALUE_W-1:0]  opnd_b,
	output logic [qdec_pkg::VALUE_W-1:0]  opnd_c,
	output logic [qdec_pkg::VALUE_W-1:0]  opnd_d,
	output logic [3:0]                    imm_mask,
	output logic [qdec_pkg::REG_W-1:0]    out_rd
);

	// Latch to decoder and selector
	logic                         bundle_valid;
	qdec_pkg::micro_op_t          micro_op;
	logic [BUNDLE_W-1:0]          parcels;
	qdec_pkg::pc_address_t        latched_ip;

	// Decoder to selector
	logic [qdec_pkg::VALUE_W-1:0] imma;
	logic [qdec_pkg::VALUE_W-1:0] immb;
	logic [qdec_pkg::VALUE_W-1:0] immc;
	logic [qdec_pkg::VALUE_W-1:0] immd;
	logic                         has_imma;
	logic                         has_immb;
	logic                         has_immc;
	logic                         has_immd;

	// Stage 1 registers the bundle, the decode is combinational behind it
	qdec_bundle_latch #(
		.NUM_PARCELS(NUM_PARCELS)
	) qdec_bundle_latch_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid    (in_valid),
		.instr_raw   (instr_raw),
		.ip          (ip),
		.bundle_valid(bundle_valid),
		.micro_op    (micro_op),
		.parcels     (parcels),
		.latched_ip  (latched_ip),
		.rs1_idx     (rs1_idx),
		.rs2_idx     (rs2_idx)
	);

	qdec_const_decode #(
		.NUM_PARCELS(NUM_PARCELS)
	) qdec_const_decode_i (
		.micro_op  (micro_op),
		.parcels   (parcels),
		.latched_ip(latched_ip),
		.imma      (imma),
		.immb      (immb),
		.immc      (immc),
		.immd      (immd),
		.has_imma  (has_imma),
		.has_immb  (has_immb),
		.has_immc  (has_immc),
		.has_immd  (has_immd)
	);

	// Stage 2 merges in the register read data and registers the operands
	qdec_operand_select qdec_operand_select_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.bundle_valid(bundle_valid),
		.rd          (micro_op.rd),
		.imma        (imma),
		.immb        (immb),
		.immc        (immc),
		.immd        (immd),
		.has_imma    (has_imma),
		.has_immb    (has_immb),
		.has_immc    (has_immc),
		.has_immd    (has_immd),
		.rf_a        (rf_a),
		.rf_b        (rf_b),
		.out_valid   (out_valid),
		.opnd_a      (opnd_a),
		.opnd_b      (opnd_b),
		.opnd_c      (opnd_c),
		.opnd_d      (opnd_d),
		.imm_mask    (imm_mask),
		.out_rd      (out_rd)
	);

endmodule

`default_nettype wire

// ==== source/qdec_operand_select.sv ====
// Operand selector that merges immediates with register read data and registers the result
`timescale 1ns/1ps
`default_nettype none

module qdec_operand_select (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          bundle_valid,
	input  logic [qdec_pkg::REG_W-1:0]    rd,
	input  logic [qdec_pkg::VALUE_W-1:0]  imma,
	input  logic [qdec_pkg::VALUE_W-1:0]  immb,
	input  logic [qdec_pkg::VALUE_W-1:0]  immc,
	input  logic [qdec_pkg::VALUE_W-1:0]  immd,
	input  logic                          has_imma,
	input  logic                          has_immb,
	input  logic                          has_immc,
	input  logic                          has_immd,
	input  logic [qdec_pkg::VALUE_W-1:0]  rf_a,
	input  logic [qdec_pkg::VALUE_W-1:0]  rf_b,
	output logic                          out_valid,
	output logic [qdec_pkg::VALUE_W-1:0]  opnd_a,
	output logic [qdec_pkg::VALUE_W-1:0]  opnd_b,
	output logic [qdec_pkg::VALUE_W-1:0]  opnd_c,
	output logic [qdec_pkg::VALUE_W-1:0]  opnd_d,
	output logic [3:0]                    imm_mask,
	output logic [qdec_pkg::REG_W-1:0]    out_rd
);

	logic [qdec_pkg::VALUE_W-1:0] sel_a;
	logic [qdec_pkg::VALUE_W-1:0] sel_b;

	// ======================================================================
	// Source select
	// ======================================================================

	// A constant always takes priority over the register file
	assign sel_a = has_imma ? imma : rf_a;
	assign sel_b = has_immb ? immb : rf_b;

	// ======================================================================
	// Result register
	// ======================================================================

	// Results only change on a bundle, so idle cycles hold the last result
	// while out_valid is low
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			opnd_a    <= '0;
			opnd_b    <= '0;
			opnd_c    <= '0;
			opnd_d    <= '0;
			imm_mask  <= 4'b0000;
			out_rd    <= '0;
		end else begin
			out_valid <= bundle_valid;
			if (bundle_valid) begin
				opnd_a   <= sel_a;
				opnd_b   <= sel_b;
				// c and d have no register path, the decoder zeroes them when absent
				opnd_c   <= immc;
				opnd_d   <= immd;
				imm_mask <= {has_immd, has_immc, has_immb, has_imma};
				out_rd   <= rd;
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/qdec_const_decode.sv ====
// Constant decoder that derives four immediates and their presence flags from opcode and prefixes
`timescale 1ns/1ps
`default_nettype none

module qdec_const_decode #(
	parameter int NUM_PARCELS = 4,
	localparam int BUNDLE_W = NUM_PARCELS * qdec_pkg::PARCEL_W
) (
	input  qdec_pkg::micro_op_t              micro_op,
	input  logic [BUNDLE_W-1:0]              parcels,
	input  qdec_pkg::pc_address_t            latched_ip,
	output logic [qdec_pkg::VALUE_W-1:0]     imma,
	output logic [qdec_pkg::VALUE_W-1:0]     immb,
	output logic [qdec_pkg::VALUE_W-1:0]     immc,
	output logic [qdec_pkg::VALUE_W-1:0]     immd,
	output logic                             has_imma,
	output logic                             has_immb,
	output logic                             has_immc,
	output logic                             has_immd
);

	localparam int EXT_W = qdec_pkg::VALUE_W - qdec_pkg::IMM_W;
	localparam int DISP_EXT_W = qdec_pkg::VALUE_W - qdec_pkg::DISP_W;
	localparam int HALF_W = qdec_pkg::VALUE_W - qdec_pkg::CPFX_VAL_W;

	// Working copies indexed by operand, 0 is a and 3 is d
	logic [qdec_pkg::VALUE_W-1:0]    imm_v [4];
	logic [3:0]                      has_v;

	// Fields of the prefix parcel under inspection
	logic [qdec_pkg::PARCEL_W-1:0]   pfx;
	logic [1:0]                      wh;
	logic [1:0]                      q;
	logic [qdec_pkg::CPFX_VAL_W-1:0] pval;

	// Memory form fields
	logic [qdec_pkg::REG_W-1:0]      rs2;
	logic [qdec_pkg::DISP_W-1:0]     disp;

	// Pre-extended immediates
	logic [qdec_pkg::VALUE_W-1:0]    imm_sx;
	logic [qdec_pkg::VALUE_W-1:0]    imm_zx;
	logic [qdec_pkg::VALUE_W-1:0]    imm_ox;
	logic [qdec_pkg::VALUE_W-1:0]    disp_sx;

	// ======================================================================
	// Field extraction
	// ======================================================================

	assign rs2  = micro_op.imm[qdec_pkg::REG_W-1:0];
	assign disp = micro_op.imm[qdec_pkg::DISP_LSB +: qdec_pkg::DISP_W];

	assign imm_sx = {{EXT_W{micro_op.imm[qdec_pkg::IMM_W-1]}}, micro_op.imm};
	assign imm_zx = {{EXT_W{1'b0}}, micro_op.imm};
	// AND immediates keep the upper bits of the source untouched
	assign imm_ox = {{EXT_W{1'b1}}, micro_op.imm};
	assign disp_sx = {{DISP_EXT_W{disp[qdec_pkg::DISP_W-1]}}, disp};

	// ======================================================================
	// Opcode pass, then prefix pass
	// ======================================================================

	always_comb begin
		imm_v[0] = qdec_pkg::VALUE_ZERO;
		imm_v[1] = qdec_pkg::VALUE_ZERO;
		imm_v[2] = qdec_pkg::VALUE_ZERO;
		imm_v[3] = qdec_pkg::VALUE_ZERO;
		has_v    = 4'b0000;
		pfx      = '0;
		wh       = 2'd0;
		q        = 2'd0;
		pval     = '0;

		case (micro_op.opcode)
			// Signed group, the immediate goes into b
			qdec_pkg::op_addi, qdec_pkg::op_subfi, qdec_pkg::op_cmpi: begin
				imm_v[1] = imm_sx;
				has_v[1] = 1'b1;
			end
			// Unsigned and logical group
			qdec_pkg::op_cmpui, qdec_pkg::op_ori, qdec_pkg::op_xori: begin
				imm_v[1] = imm_zx;
				has_v[1] = 1'b1;
			end
			qdec_pkg::op_andi: begin
				imm_v[1] = imm_ox;
				has_v[1] = 1'b1;
			end
			// Load immediate adds to a hardwired zero in a
			qdec_pkg::op_loadi: begin
				imm_v[0] = qdec_pkg::VALUE_ZERO;
				has_v[0] = 1'b1;
				imm_v[1] = imm_sx;
				has_v[1] = 1'b1;
			end
			// Register 0 in a memory form becomes a zero constant
			qdec_pkg::op_load, qdec_pkg::op_store: begin
				if (micro_op.rs1 == '0) begin
					has_v[0] = 1'b1;
				end
				if (rs2 == '0) begin
					has_v[1] = 1'b1;
				end
				imm_v[2] = disp_sx;
				has_v[2] = 1'b1;
			end
			// Pointer relative, the base is the instruction pointer
			qdec_pkg::op_ldip: begin
				imm_v[0] = latched_ip;
				has_v[0] = 1'b1;
				if (rs2 == '0) begin
					has_v[1] = 1'b1;
				end
				imm_v[2] = disp_sx;
				has_v[2] = 1'b1;
			end
			default: begin
				has_v = 4'b0000;
			end
		endcase

		// Prefixes are applied in parcel order so the last one wins
		for (int n = 1; n < NUM_PARCELS; n++) begin
			pfx  = parcels[n*qdec_pkg::PARCEL_W +: qdec_pkg::PARCEL_W];
			wh   = pfx[qdec_pkg::CPFX_WH_LSB +: 2];
			q    = pfx[qdec_pkg::CPFX_Q_LSB +: 2];
			pval = pfx[qdec_pkg::CPFX_VAL_LSB +: qdec_pkg::CPFX_VAL_W];
			if (pfx[7:0] == qdec_pkg::op_cpfx) begin
				// Quarters 2 and 3 are reserved and leave the target alone
				if (q == qdec_pkg::CPFX_Q_REPLACE) begin
					imm_v[wh] = {{HALF_W{pval[qdec_pkg::CPFX_VAL_W-1]}}, pval};
					has_v[wh] = 1'b1;
				end else if (q == qdec_pkg::CPFX_Q_HIGH) begin
					imm_v[wh] = {pval, imm_v[wh][qdec_pkg::CPFX_VAL_W-1:0]};
					has_v[wh] = 1'b1;
				end
			end
		end
	end

	assign imma     = imm_v[0];
	assign immb     = imm_v[1];
	assign immc     = imm_v[2];
	assign immd     = imm_v[3];
	assign has_imma = has_v[0];
	assign has_immb = has_v[1];
	assign has_immc = has_v[2];
	assign has_immd = has_v[3];

endmodule

`default_nettype wire

// ==== source/qdec_bundle_latch.sv ====
// Bundle latch that captures a parcel bundle and its instruction pointer and unpacks the micro-op
`timescale 1ns/1ps
`default_nettype none

module qdec_bundle_latch #(
	parameter int NUM_PARCELS = 4,
	localparam int BUNDLE_W = NUM_PARCELS * qdec_pkg::PARCEL_W
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           in_valid,
	input  logic [BUNDLE_W-1:0]            instr_raw,
	input  qdec_pkg::pc_address_t          ip,
	output logic                           bundle_valid,
	output qdec_pkg::micro_op_t            micro_op,
	output logic [BUNDLE_W-1:0]            parcels,
	output qdec_pkg::pc_address_t          latched_ip,
	output logic [qdec_pkg::REG_W-1:0]     rs1_idx,
	output logic [qdec_pkg::REG_W-1:0]     rs2_idx
);

	// ======================================================================
	// Capture
	// ======================================================================

	// The bundle strobe trails in_valid by one cycle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			bundle_valid <= 1'b0;
		end else begin
			bundle_valid <= in_valid;
		end
	end

	// Bundle and pointer are held until the next strobe
	// The decoder reads them during the bundle_valid cycle, so a back-to-back
	// bundle replaces them on the edge where the selector takes the result
	always_ff @(posedge clk) begin
		if (in_valid) begin
			parcels    <= instr_raw;
			latched_ip <= ip;
		end
	end

	// ======================================================================
	// Unpack
	// ======================================================================

	// Parcel 0 always holds the instruction itself
	assign micro_op = qdec_pkg::micro_op_t'(parcels[qdec_pkg::PARCEL_W-1:0]);

	// Read indices go straight out to the register file, which answers
	// combinationally in the bundle_valid cycle
	assign rs1_idx = micro_op.rs1;

	// rs2 only means something for the memory forms, where it sits in the
	// lowest bits of the immediate field
	assign rs2_idx = micro_op.imm[qdec_pkg::REG_W-1:0];

endmodule

`default_nettype wire

// ==== source/qdec_pkg.sv ====
// Constant-decode package with the parcel layout, opcode encodings and micro-op format
`default_nettype none

package qdec_pkg;

	// ======================================================================
	// Widths
	// ======================================================================

	// Every parcel of a bundle has this width, instruction and prefix alike
	localparam int PARCEL_W = 48;

	// Operand and immediate width on the result side
	localparam int VALUE_W = 64;

	// Register index width; register 0 always reads as zero
	localparam int REG_W = 6;

	// Instruction pointer width
	localparam int PC_W = 64;

	// Immediate field of an instruction parcel
	localparam int IMM_W = 27;

	// In the memory form the displacement takes the upper 19 immediate bits
	// and rs2 sits in the lowest REG_W bits of the immediate
	localparam int DISP_LSB = 8;
	localparam int DISP_W = 19;

	// ======================================================================
	// Constant prefix layout
	// ======================================================================

	// Target operand, 0 to 3 select a to d
	localparam int CPFX_WH_LSB = 8;

	// Quarter code, selects how the value lands in the target
	localparam int CPFX_Q_LSB = 10;

	// Payload of the prefix
	localparam int CPFX_VAL_LSB = 16;
	localparam int CPFX_VAL_W = 32;

	// Quarter 0 replaces the constant with the sign-extended value
	localparam logic [1:0] CPFX_Q_REPLACE = 2'd0;

	// Quarter 1 writes the value into the upper half and keeps the lower half
	localparam logic [1:0] CPFX_Q_HIGH = 2'd1;

	// All-zero operand value
	localparam logic [VALUE_W-1:0] VALUE_ZERO = '0;

	// ======================================================================
	// Types
	// ======================================================================

	typedef logic [PC_W-1:0] pc_address_t;

	// Opcodes known to the constant decoder; anything else carries no constant
	typedef enum logic [7:0] {
		op_addi  = 8'd4,
		op_subfi = 8'd5,
		op_cmpi  = 8'd6,
		op_cmpui = 8'd7,
		op_andi  = 8'd8,
		op_ori   = 8'd9,
		op_xori  = 8'd10,
		op_loadi = 8'd11,
		op_load  = 8'd64,
		op_ldip  = 8'd66,
		op_store = 8'd80,
		op_cpfx  = 8'd127
	} opcode_t;

	// Instruction parcel, most significant field first
	typedef struct packed {
		logic             rsvd;
		logic [IMM_W-1:0] imm;
		logic [REG_W-1:0] rs1;
		logic [REG_W-1:0] rd;
		opcode_t          opcode;
	} micro_op_t;

endpackage

`default_nettype wire
